// ==== access_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module access_fsm (
  input  wire logic i_clk,
  input  wire logic i_rst,
  input  wire logic i_req_valid,
  output logic      o_req_ready,
  input  wire logic i_last,
  input  wire logic i_ack,
  output logic      o_load,
  output logic      o_byte_req,
  output logic      o_step,
  output logic      o_rsp_valid,
  input  wire logic i_rsp_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   strobe_q;

  always_comb begin
    state_d     = state_q;
    o_req_ready = 1'b0;
    o_load      = 1'b0;
    o_step      = 1'b0;
    o_rsp_valid = 1'b0;
    case (state_q)
      ST_IDLE: begin
        o_req_ready = 1'b1;
        if (i_req_valid) begin
          o_load  = 1'b1;
          state_d = ST_ISSUE;
        end
      end
      // Strobe goes out registered, next cycle
      ST_ISSUE: state_d = ST_WAIT;
      ST_WAIT: begin
        if (i_ack) begin
          o_step  = 1'b1;
          state_d = i_last ? ST_RESP : ST_ISSUE;
        end
      end
      // Hold until the response is taken
      ST_RESP: begin
        o_rsp_valid = 1'b1;
        if (i_rsp_ready)
          state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= ST_IDLE;
      strobe_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      strobe_q <= (state_q == ST_ISSUE);
    end
  end

  // One pulse per byte
  assign o_byte_req = strobe_q;

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
mem_pkg.sv
byte_ram.sv
video_ram.sv
io_regs.sv
mem_byte_router.sv
lane_counter.sv
access_fsm.sv
mem_datapath.sv
mem_top.sv
tb_mem_top.sv

// ==== byte_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_ram #(
  parameter int ADDR_W = mem_pkg::BOOT_AW
) (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_sel,
  input  wire mem_pkg::byte_req_t i_req,
  output mem_pkg::byte_rsp_t      o_rsp
);

  logic [7:0] mem [2**ADDR_W];
  logic [7:0] rdata_q;
  logic       ack_q;

  // Storage and synchronous read
  always_ff @(posedge i_clk) begin
    if (i_sel) begin
      if (i_req.write)
        mem[i_req.addr[ADDR_W-1:0]] <= i_req.wdata;
      else
        rdata_q <= mem[i_req.addr[ADDR_W-1:0]];
    end
  end

  // Ack follows the strobe by one clock
  always_ff @(posedge i_clk) begin
    if (i_rst)
      ack_q <= 1'b0;
    else
      ack_q <= i_sel;
  end

  assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_regs (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_hex_sel,
  input  wire logic               i_gpio_sel,
  input  wire mem_pkg::byte_req_t i_req,
  output mem_pkg::byte_rsp_t      o_rsp,
  input  wire logic [7:0]         i_gpio_data,
  input  wire logic [7:0]         i_gpio_ctrl,
  output logic [31:0]             o_hex,
  output logic [3:0]              o_gpio_ctrl
);

  import mem_pkg::*;

  logic [3:0][7:0]   hex_q;
  logic [3:0]        ctrl_q;
  logic [7:0]        rdata_q;
  logic              ack_q;
  logic [IO_AW-1:0]  off;

  assign off = i_req.addr[IO_AW-1:0];

  // Writable registers
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      hex_q  <= '0;
      ctrl_q <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= i_hex_sel | i_gpio_sel;
      if (i_hex_sel && i_req.write)
        hex_q[off] <= i_req.wdata;
      // Only offset 2 is writable in the GPIO block
      if (i_gpio_sel && i_req.write && off == 2'd2)
        ctrl_q <= i_req.wdata[3:0];
    end
  end

  // Read byte, GPIO inputs sampled at the strobe
  always_ff @(posedge i_clk) begin
    if (i_hex_sel) begin
      rdata_q <= hex_q[off];
    end else if (i_gpio_sel) begin
      case (off)
        2'd0:    rdata_q <= i_gpio_data;
        2'd1:    rdata_q <= i_gpio_ctrl;
        2'd2:    rdata_q <= {4'h0, ctrl_q};
        default: rdata_q <= 8'h00;
      endcase
    end
  end

  assign o_rsp       = '{ack: ack_q, rdata: rdata_q};
  assign o_hex       = hex_q;
  assign o_gpio_ctrl = ctrl_q;

endmodule

`default_nettype wire

// ==== lane_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module lane_counter (
  input  wire logic           i_clk,
  input  wire logic           i_rst,
  input  wire logic           i_load,
  input  wire mem_pkg::size_e i_size,
  input  wire logic           i_step,
  output logic [1:0]          o_lane,
  output logic                o_last
);

  logic [1:0] lane_q;
  logic [1:0] final_q;

  // Size code doubles as the index of the final lane
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lane_q  <= 2'd0;
      final_q <= 2'd0;
    end else if (i_load) begin
      lane_q  <= 2'd0;
      final_q <= i_size;
    end else if (i_step) begin
      lane_q <= lane_q + 2'd1;
    end
  end

  assign o_lane = lane_q;
  assign o_last = (lane_q == final_q);

endmodule

`default_nettype wire

// ==== mem_byte_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_byte_router (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_strobe,
  input  wire mem_pkg::byte_req_t i_req,
  output logic                    o_boot_sel,
  output logic                    o_vid_sel,
  output logic                    o_hex_sel,
  output logic                    o_gpio_sel,
  input  wire mem_pkg::byte_rsp_t i_boot_rsp,
  input  wire mem_pkg::byte_rsp_t i_vid_rsp,
  input  wire mem_pkg::byte_rsp_t i_io_rsp,
  output mem_pkg::byte_rsp_t      o_rsp
);

  import mem_pkg::*;

  // One flag per target, held for the data return
  typedef struct packed {
    logic boot;
    logic vid;
    logic io;
    logic miss;
  } hit_t;

  hit_t hit;
  hit_t sel_q;
  logic miss_ack_q;

  // Decode on the upper address bits of each region
  always_comb begin
    hit.boot = (i_req.addr[31:BOOT_AW] == BOOT_BASE[31:BOOT_AW]);
    hit.vid  = (i_req.addr[31:VID_AW]  == VID_BASE[31:VID_AW]);
    hit.io   = (i_req.addr[31:IO_AW]   == HEX_BASE[31:IO_AW]) ||
               (i_req.addr[31:IO_AW]   == GPIO_BASE[31:IO_AW]);
    hit.miss = !(hit.boot || hit.vid || hit.io);
  end

  // Strobe to exactly one target
  assign o_boot_sel = i_strobe & hit.boot;
  assign o_vid_sel  = i_strobe & hit.vid;
  assign o_hex_sel  = i_strobe & (i_req.addr[31:IO_AW] == HEX_BASE[31:IO_AW]);
  assign o_gpio_sel = i_strobe & (i_req.addr[31:IO_AW] == GPIO_BASE[31:IO_AW]);

  // Remember the target, and answer unmapped bytes here
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sel_q      <= '0;
      miss_ack_q <= 1'b0;
    end else begin
      miss_ack_q <= i_strobe & hit.miss;
      if (i_strobe)
        sel_q <= hit;
    end
  end

  // Return path
  always_comb begin
    o_rsp.ack = i_boot_rsp.ack | i_vid_rsp.ack | i_io_rsp.ack | miss_ack_q;
    if (sel_q.boot)
      o_rsp.rdata = i_boot_rsp.rdata;
    else if (sel_q.vid)
      o_rsp.rdata = i_vid_rsp.rdata;
    else if (sel_q.io)
      o_rsp.rdata = i_io_rsp.rdata;
    else
      o_rsp.rdata = 8'h00; // Unmapped reads as zero
  end

endmodule

`default_nettype wire

// ==== mem_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_datapath (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_load,
  input  wire mem_pkg::mem_req_t  i_req,
  input  wire logic [1:0]         i_lane,
  input  wire logic               i_step,
  input  wire mem_pkg::byte_rsp_t i_rsp,
  output mem_pkg::byte_req_t      o_byte,
  output mem_pkg::mem_rsp_t       o_rsp
);

  import mem_pkg::*;

  mem_req_t  req_q;
  mem_word_u rd_q;

  // Request held for the whole access
  always_ff @(posedge i_clk) begin
    if (i_load)
      req_q <= i_req;
  end

  // Read word built lane by lane
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_q.word <= 32'h0;
    end else if (i_load) begin
      // Cleared so unused upper lanes read as zero
      rd_q.word <= 32'h0;
    end else if (i_step && !req_q.write) begin
      rd_q.lane[i_lane] <= i_rsp.rdata;
    end
  end

  // Little-endian, lane k goes to base plus k
  always_comb begin
    o_byte.addr  = req_q.addr + {30'h0, i_lane};
    o_byte.wdata = req_q.wdata.lane[i_lane];
    o_byte.write = req_q.write;
  end

  // Writes leave the word at zero
  assign o_rsp.rdata = rd_q;

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // Address map
  localparam logic [31:0] BOOT_BASE = 32'h0000_0000;
  localparam int          BOOT_AW   = 12;
  localparam logic [31:0] VID_BASE  = 32'h0001_0000;
  localparam int          VID_AW    = 14;
  localparam logic [31:0] HEX_BASE  = 32'h0002_0000;
  localparam logic [31:0] GPIO_BASE = 32'h0002_1000;

  // Offset width inside each I/O block
  localparam int          IO_AW     = 2;

  // Access size, value is byte count minus one
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd3
  } size_e;

  // Data word, whole or per byte lane
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lane;
  } mem_word_u;

  // Request from the processor side
  typedef struct packed {
    logic [31:0] addr;
    mem_word_u   wdata;
    size_e       size;
    logic        write;
  } mem_req_t;

  // Response, read data zero-extended
  typedef struct packed {
    mem_word_u rdata;
  } mem_rsp_t;

  // One byte access on the internal bus
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  wdata;
    logic        write;
  } byte_req_t;

  // Target answer, ack one clock after strobe
  typedef struct packed {
    logic       ack;
    logic [7:0] rdata;
  } byte_rsp_t;

endpackage

`default_nettype wire

// ==== mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_top (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst,
  input  wire logic                       i_req_valid,
  output logic                            o_req_ready,
  input  wire mem_pkg::mem_req_t          i_req,
  output logic                            o_rsp_valid,
  input  wire logic                       i_rsp_ready,
  output mem_pkg::mem_rsp_t               o_rsp,
  input  wire logic [mem_pkg::VID_AW-1:0] i_vid_addr,
  output logic [7:0]                      o_vid_data,
  output logic [31:0]                     o_hex,
  input  wire logic [7:0]                 i_gpio_data,
  input  wire logic [7:0]                 i_gpio_ctrl,
  output logic [3:0]                      o_gpio_ctrl
);

  import mem_pkg::*;

  // Sequencer controls
  logic      load;
  logic      byte_strobe;
  logic      step;
  logic      last;
  logic [1:0] lane;

  // Internal byte bus
  byte_req_t byte_req;
  byte_rsp_t byte_rsp;

  // Target strobes and answers
  logic      boot_sel;
  logic      vid_sel;
  logic      hex_sel;
  logic      gpio_sel;
  byte_rsp_t boot_rsp;
  byte_rsp_t vid_rsp;
  byte_rsp_t io_rsp;

  access_fsm access_fsm_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_last      (last),
    .i_ack       (byte_rsp.ack),
    .o_load      (load),
    .o_byte_req  (byte_strobe),
    .o_step      (step),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready)
  );

  lane_counter lane_counter_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_load (load),
    .i_size (i_req.size),
    .i_step (step),
    .o_lane (lane),
    .o_last (last)
  );

  mem_datapath mem_datapath_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_load (load),
    .i_req  (i_req),
    .i_lane (lane),
    .i_step (step),
    .i_rsp  (byte_rsp),
    .o_byte (byte_req),
    .o_rsp  (o_rsp)
  );

  mem_byte_router mem_byte_router_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_strobe   (byte_strobe),
    .i_req      (byte_req),
    .o_boot_sel (boot_sel),
    .o_vid_sel  (vid_sel),
    .o_hex_sel  (hex_sel),
    .o_gpio_sel (gpio_sel),
    .i_boot_rsp (boot_rsp),
    .i_vid_rsp  (vid_rsp),
    .i_io_rsp   (io_rsp),
    .o_rsp      (byte_rsp)
  );

  // Boot RAM, 4 KiB
  byte_ram #(
    .ADDR_W (BOOT_AW)
  ) boot_ram_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_sel (boot_sel),
    .i_req (byte_req),
    .o_rsp (boot_rsp)
  );

  // Video RAM with display read port
  video_ram video_ram_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_sel      (vid_sel),
    .i_req      (byte_req),
    .o_rsp      (vid_rsp),
    .i_vid_addr (i_vid_addr),
    .o_vid_data (o_vid_data)
  );

  io_regs io_regs_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_hex_sel   (hex_sel),
    .i_gpio_sel  (gpio_sel),
    .i_req       (byte_req),
    .o_rsp       (io_rsp),
    .i_gpio_data (i_gpio_data),
    .i_gpio_ctrl (i_gpio_ctrl),
    .o_hex       (o_hex),
    .o_gpio_ctrl (o_gpio_ctrl)
  );

endmodule

`default_nettype wire

// ==== tb_mem_model.svh ====
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Copies of every target the bridge can reach
logic [7:0]      boot_m [2**BOOT_AW];
logic [7:0]      vid_m  [2**VID_AW];
logic [3:0][7:0] hex_m       = '0;
logic [3:0]      ctrl_m      = '0;
logic [7:0]      gpio_data_m = '0;
logic [7:0]      gpio_ctrl_m = '0;

// Byte at one address, anything outside the map reads as zero
function automatic logic [7:0] read_model_byte(input logic [31:0] a);
  logic [7:0] d;
  d = 8'h00;
  if (a - BOOT_BASE < 2**BOOT_AW) begin
    d = boot_m[a - BOOT_BASE];
  end else if (a - VID_BASE < 2**VID_AW) begin
    d = vid_m[a - VID_BASE];
  end else if (a - HEX_BASE < 4) begin
    d = hex_m[a[1:0]];
  end else if (a - GPIO_BASE < 4) begin
    case (a[1:0])
      2'd0:    d = gpio_data_m;
      2'd1:    d = gpio_ctrl_m;
      2'd2:    d = {4'h0, ctrl_m};
      default: d = 8'h00;
    endcase
  end
  return d;
endfunction

// Writes outside the map and to read-only GPIO offsets vanish
task automatic store_model_byte(input logic [31:0] a, input logic [7:0] d);
  if (a - BOOT_BASE < 2**BOOT_AW)
    boot_m[a - BOOT_BASE] = d;
  else if (a - VID_BASE < 2**VID_AW)
    vid_m[a - VID_BASE] = d;
  else if (a - HEX_BASE < 4)
    hex_m[a[1:0]] = d;
  else if (a - GPIO_BASE == 2)
    ctrl_m = d[3:0];  // control nibble only
endtask

// Whole request, byte k at base plus k, upper lanes left at zero
task automatic apply_to_model(input mem_req_t rq, output mem_rsp_t rs);
  int n;
  int k;
  n = int'(rq.size) + 1;
  rs.rdata.word = 32'h0;
  for (k = 0; k < n; k++) begin
    if (rq.write)
      store_model_byte(rq.addr + k, rq.wdata.lane[k]);
    else
      rs.rdata.lane[k] = read_model_byte(rq.addr + k);
  end
endtask

`endif

// ==== tb_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_top;

  import mem_pkg::*;

  localparam int CLK_NS     = 8;
  localparam int N_PREFILL  = (2**BOOT_AW + 2**VID_AW) / 4;
  localparam int N_RAM      = 300;
  localparam int N_UNMAP    = 40;
  localparam int N_IO       = 80;
  localparam int N_VID      = 100;
  localparam int N_BP       = 150;
  // Four bytes of three cycles each plus room for long back-pressure
  localparam int REQ_CYCLES = 64;
  localparam int TOTAL_REQ  = N_PREFILL + 2 * N_RAM + 3 * N_UNMAP + N_IO + N_BP;
  localparam int RUN_CYCLES = 64 + TOTAL_REQ * REQ_CYCLES + 4 * N_VID;

  logic              clk = 1'b0;
  logic              rst;
  logic              req_valid;
  logic              req_ready;
  mem_req_t          req;
  logic              rsp_valid;
  logic              rsp_ready;
  mem_rsp_t          rsp;
  logic [VID_AW-1:0] vid_addr;
  logic [7:0]        vid_data;
  logic [31:0]       hex;
  logic [7:0]        gpio_data;
  logic [7:0]        gpio_ctrl_in;
  logic [3:0]        gpio_ctrl_out;

  int unsigned seed = 32'hd21;
  int errors    = 0;
  int checks    = 0;
  int tests     = 0;
  int test_errs = 0;
  int req_count = 0;
  int req_fires = 0;
  int rsp_fires = 0;

  `include "tb_mem_model.svh"

  mem_top mem_top_i (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req       (req),
    .o_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready),
    .o_rsp       (rsp),
    .i_vid_addr  (vid_addr),
    .o_vid_data  (vid_data),
    .o_hex       (hex),
    .i_gpio_data (gpio_data),
    .i_gpio_ctrl (gpio_ctrl_in),
    .o_gpio_ctrl (gpio_ctrl_out)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Watchdog sized from the request count
  initial begin
    #(RUN_CYCLES * CLK_NS);
    $display("Watchdog expired after %0d cycles, the run did not complete", RUN_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  // Count port handshakes half a cycle before the edge that completes them
  always @(negedge clk) begin
    if (!rst) begin
      if (req_valid && req_ready)
        req_fires++;
      if (rsp_valid && rsp_ready)
        rsp_fires++;
    end
  end

  task automatic report_fault(input string what);
    errors++;
    $display("** Error at %0t: %s", $time, what);
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic rsp_check(input string name, input mem_rsp_t got, input mem_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name,
               got.rdata.word, exp.rdata.word);
    end
  endtask

  task automatic hex_check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic ctrl_check(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic pixel_check(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic start_test();
    test_errs = errors;
  endtask

  task automatic close_test(input string name);
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == test_errs) ? "ok" : "failed", errors - test_errs);
  endtask

  // Fill value folds in every address bit
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic size_e random_size();
    case ($urandom % 3)
      0:       return SZ_BYTE;
      1:       return SZ_HALF;
      default: return SZ_WORD;
    endcase
  endfunction

  function automatic logic [31:0] ram_address();
    if ($urandom % 2)
      return BOOT_BASE + ($urandom % 2**BOOT_AW);
    return VID_BASE + ($urandom % 2**VID_AW);
  endfunction

  // Never mapped even with three more bytes added
  function automatic logic [31:0] gap_address();
    if ($urandom % 2)
      return 32'h0000_1000 + ($urandom % 32'h0000_e000);
    return 32'h4000_0000 + ($urandom % 32'h1000_0000);
  endfunction

  function automatic logic [31:0] io_address();
    return (($urandom % 2) ? HEX_BASE : GPIO_BASE) + ($urandom % 4);
  endfunction

  function automatic logic [31:0] any_address();
    case ($urandom % 4)
      0, 1:    return ram_address();
      2:       return gap_address();
      default: return io_address();
    endcase
  endfunction

  // One full request and response with optional back-pressure
  task automatic run_request(input mem_req_t rq, input logic bp);
    mem_rsp_t exp;
    mem_rsp_t first;
    mem_req_t dummy;
    logic     accepted;
    logic     seen;
    logic     taken;
    apply_to_model(rq, exp);
    // Offered while busy and never to be taken
    dummy.addr       = 32'h4000_0000 | ($urandom & 32'h0fff_fffc);
    dummy.wdata.word = $urandom;
    dummy.size       = SZ_WORD;
    dummy.write      = 1'b1;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= rq;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (rsp_valid)
        report_fault("response present with no request pending");
      accepted = req_ready;
      @(posedge clk);
    end
    req_count++;
    req_valid <= bp;
    req       <= bp ? dummy : rq;
    seen  = 1'b0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (req_valid && req_ready)
        report_fault("request accepted while the bridge was busy");
      if (rsp_valid) begin
        if (seen)
          rsp_check("o_rsp (held)", rsp, first);
        else
          first = rsp;
        seen  = 1'b1;
        taken = rsp_ready;
      end else if (seen) begin
        report_fault("response withdrawn before it was taken");
      end
      @(posedge clk);
      if (!taken)
        rsp_ready <= bp ? ($urandom % 3 != 0) : 1'b1;
    end
    req_valid <= 1'b0;
    rsp_check("o_rsp", first, exp);
  endtask

  initial begin
    mem_req_t          rq;
    int                i;
    logic [31:0]       a;
    logic [VID_AW-1:0] va;
    seed = $urandom(seed);
    rst          <= 1'b1;
    req_valid    <= 1'b0;
    req          <= '0;
    rsp_ready    <= 1'b1;
    vid_addr     <= '0;
    gpio_data    <= 8'h00;
    gpio_ctrl_in <= 8'h00;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    start_test();
    @(negedge clk);
    flag_check("o_req_ready", req_ready, 1'b1);
    flag_check("o_rsp_valid", rsp_valid, 1'b0);
    hex_check("o_hex", hex, 32'h0);
    ctrl_check("o_gpio_ctrl", gpio_ctrl_out, 4'h0);
    close_test("reset values");

    // Known contents everywhere before random reads
    start_test();
    for (i = 0; i < N_PREFILL; i++) begin
      if (i < 2**BOOT_AW / 4)
        a = BOOT_BASE + 4 * i;
      else
        a = VID_BASE + 4 * (i - 2**BOOT_AW / 4);
      rq.addr       = a;
      rq.size       = SZ_WORD;
      rq.write      = 1'b1;
      rq.wdata.lane = {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
      run_request(rq, 1'b0);
    end
    close_test("ram prefill");

    start_test();
    for (i = 0; i < N_RAM; i++) begin
      rq.addr       = ram_address();
      rq.size       = random_size();
      rq.write      = 1'b1;
      rq.wdata.word = $urandom;
      run_request(rq, 1'b0);
      // Read back with a fresh size so unaligned cases cross words
      rq.size       = random_size();
      rq.write      = 1'b0;
      rq.wdata.word = $urandom;
      run_request(rq, 1'b0);
    end
    close_test("ram write and read");

    start_test();
    for (i = 0; i < N_UNMAP; i++) begin
      a             = gap_address();
      rq.addr       = a;
      rq.size       = random_size();
      rq.write      = 1'b1;
      rq.wdata.word = $urandom;
      run_request(rq, 1'b0);
      rq.write = 1'b0;
      run_request(rq, 1'b0);
      // Boot word a partial decode would alias to
      rq.addr = BOOT_BASE + (a & 32'h0000_0ffc);
      rq.size = SZ_WORD;
      run_request(rq, 1'b0);
    end
    close_test("unmapped range");

    start_test();
    for (i = 0; i < N_IO; i++) begin
      a = $urandom;
      @(posedge clk);
      gpio_data    <= a[7:0];
      gpio_ctrl_in <= a[15:8];
      gpio_data_m  = a[7:0];
      gpio_ctrl_m  = a[15:8];
      rq.addr       = io_address();
      rq.size       = random_size();
      rq.write      = a[16] | a[17];
      rq.wdata.word = $urandom;
      run_request(rq, 1'b0);
      @(negedge clk);
      hex_check("o_hex", hex, hex_m);
      ctrl_check("o_gpio_ctrl", gpio_ctrl_out, ctrl_m);
    end
    close_test("io registers");

    // Display port byte due one clock after the address
    start_test();
    for (i = 0; i < N_VID; i++) begin
      a  = $urandom;
      va = vid_addr;
      @(posedge clk);
      vid_addr <= a[VID_AW-1:0];
      @(negedge clk);
      // Still the byte of the previous address
      pixel_check("o_vid_data", vid_data, vid_m[va]);
      @(posedge clk);
      @(negedge clk);
      pixel_check("o_vid_data", vid_data, vid_m[vid_addr]);
    end
    close_test("display port");

    start_test();
    for (i = 0; i < N_BP; i++) begin
      a             = $urandom;
      rq.addr       = any_address();
      rq.size       = random_size();
      rq.write      = a[0];
      rq.wdata.word = $urandom;
      run_request(rq, 1'b1);
    end
    if (req_fires != req_count || rsp_fires != req_count)
      report_fault("handshake counts do not match the requests issued");
    close_test("back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== video_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_ram (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  input  wire logic                     i_sel,
  input  wire mem_pkg::byte_req_t       i_req,
  output mem_pkg::byte_rsp_t            o_rsp,
  input  wire logic [mem_pkg::VID_AW-1:0] i_vid_addr,
  output logic [7:0]                    o_vid_data
);

  import mem_pkg::*;

  logic [7:0] mem [2**VID_AW];
  logic [7:0] rdata_q;
  logic       ack_q;

  // Bus port, read/write
  always_ff @(posedge i_clk) begin
    if (i_sel) begin
      if (i_req.write)
        mem[i_req.addr[VID_AW-1:0]] <= i_req.wdata;
      else
        rdata_q <= mem[i_req.addr[VID_AW-1:0]];
    end
  end

  // Display port, read only, every cycle
  always_ff @(posedge i_clk) begin
    o_vid_data <= mem[i_vid_addr];
  end

  // Bus ack one clock after strobe
  always_ff @(posedge i_clk) begin
    if (i_rst)
      ack_q <= 1'b0;
    else
      ack_q <= i_sel;
  end

  assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire
